// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int data_w  = 16;
    localparam int reg_cnt = 8;

    // opcodes, anything else is a nop
    localparam logic [6:0] op_mov = 7'd1;
    localparam logic [6:0] op_ldd = 7'd2;
    localparam logic [6:0] op_ldo = 7'd3;
    localparam logic [6:0] op_ldi = 7'd4;
    localparam logic [6:0] op_std = 7'd5;
    localparam logic [6:0] op_sto = 7'd6;
    localparam logic [6:0] op_add = 7'd7;
    localparam logic [6:0] op_adi = 7'd8;
    localparam logic [6:0] op_adc = 7'd9;
    localparam logic [6:0] op_sub = 7'd10;
    localparam logic [6:0] op_suc = 7'd11;
    localparam logic [6:0] op_cmp = 7'd12;
    localparam logic [6:0] op_cmi = 7'd13;
    localparam logic [6:0] op_jmp = 7'd14;
    localparam logic [6:0] op_jal = 7'd15;
    localparam logic [6:0] op_srl = 7'd16;
    localparam logic [6:0] op_srs = 7'd17;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_pass_l = 4'd9;
    localparam logic [3:0] alu_pass_r = 4'd10;

    localparam int flag_zero  = 0;
    localparam int flag_carry = 1;
    localparam int flag_neg   = 2;
    localparam int flag_ovf   = 3;
    localparam int flag_par   = 4;

    // jump conditions in instr[10:7]
    localparam logic [3:0] cond_carry   = 4'd1;
    localparam logic [3:0] cond_eq      = 4'd2;
    localparam logic [3:0] cond_lt      = 4'd3;
    localparam logic [3:0] cond_gt      = 4'd4;
    localparam logic [3:0] cond_le      = 4'd5;
    localparam logic [3:0] cond_ge      = 4'd6;
    localparam logic [3:0] cond_ne      = 4'd7;
    localparam logic [3:0] cond_ovf     = 4'd8;
    localparam logic [3:0] cond_ovf_alt = 4'd9;

endpackage

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder import cpu_pkg::*; (
    input  wire [15:0]        instr,
    input  wire [4:0]         flags,
    input  wire               mem_busy,
    input  wire               mem_ready,
    output logic              pc_inc,
    output logic              pc_ie,
    output logic              reg_in_mux_ctl,
    output logic              alu_r_mux_ctl,
    output logic              alu_cin,
    output logic              ram_write,
    output logic              ram_read,
    output logic              alu_flags_ie,
    output logic              reg_sr_in,
    output logic              sr_ie,
    output logic              sr_pc_over,
    output logic [3:0]        alu_mode,
    output logic [3:0]        reg_l_ctl,
    output logic [3:0]        reg_r_ctl,
    output logic [reg_cnt-1:0] gp_reg_ie
);

    logic [6:0] opcode;
    logic [2:0] tg_reg;
    logic [2:0] fo_reg;
    logic [2:0] so_reg;
    logic [3:0] cond;
    logic       jmp_en;

    assign opcode = instr[6:0];
    assign tg_reg = instr[9:7];
    assign fo_reg = instr[12:10];
    assign so_reg = instr[15:13];
    assign cond   = instr[10:7]; // overlaps tg_reg, jmp has no target

    always_comb begin
        pc_inc         = 1'b1;
        pc_ie          = 1'b0;
        reg_in_mux_ctl = 1'b0;
        alu_r_mux_ctl  = 1'b0;
        alu_cin        = 1'b0;
        ram_write      = 1'b0;
        ram_read       = 1'b0;
        alu_flags_ie   = 1'b0;
        reg_sr_in      = 1'b0;
        sr_ie          = 1'b0;
        sr_pc_over     = 1'b0;
        alu_mode       = alu_add;
        reg_l_ctl      = 4'd0;
        reg_r_ctl      = 4'd0;
        gp_reg_ie      = '0;
        case (opcode)
            op_mov: begin
                alu_mode          = alu_pass_l;
                reg_l_ctl         = {1'b0, fo_reg};
                gp_reg_ie[tg_reg] = 1'b1;
            end
            op_ldd, op_ldo: begin
                // address stays steady through the whole access
                if (opcode == op_ldd) begin
                    alu_mode = alu_pass_r; // imm
                end else begin
                    alu_mode  = alu_add; // reg + imm
                    reg_l_ctl = {1'b0, fo_reg};
                end
                alu_r_mux_ctl  = 1'b1;
                reg_in_mux_ctl = 1'b1;
                if (mem_busy) begin
                    pc_inc = 1'b0;
                end else if (mem_ready) begin
                    gp_reg_ie[tg_reg] = 1'b1; // data valid this cycle
                end else begin
                    ram_read = 1'b1;
                    pc_inc   = 1'b0;
                end
            end
            op_ldi: begin
                alu_mode          = alu_pass_r;
                alu_r_mux_ctl     = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
            end
            op_std: begin
                alu_mode      = alu_pass_r;
                alu_r_mux_ctl = 1'b1;
                reg_r_ctl     = {1'b0, fo_reg};
                if (mem_busy) begin
                    pc_inc = 1'b0; // back-pressure
                end else begin
                    ram_write = 1'b1;
                end
            end
            op_sto: begin
                alu_mode      = alu_add;
                alu_r_mux_ctl = 1'b1;
                reg_l_ctl     = {1'b0, so_reg};
                reg_r_ctl     = {1'b0, fo_reg};
                if (mem_busy) begin
                    pc_inc = 1'b0;
                end else begin
                    ram_write = 1'b1;
                end
            end
            op_add, op_adc: begin
                alu_mode          = alu_add;
                reg_l_ctl         = {1'b0, fo_reg};
                reg_r_ctl         = {1'b0, so_reg};
                alu_cin           = (opcode == op_adc) ? flags[flag_carry] : 1'b0;
                gp_reg_ie[tg_reg] = 1'b1;
                alu_flags_ie      = 1'b1;
            end
            op_adi: begin
                alu_mode          = alu_add;
                reg_l_ctl         = {1'b0, fo_reg};
                alu_r_mux_ctl     = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
                alu_flags_ie      = 1'b1;
            end
            op_sub, op_suc: begin
                alu_mode          = alu_sub;
                reg_l_ctl         = {1'b0, fo_reg};
                reg_r_ctl         = {1'b0, so_reg};
                alu_cin           = (opcode == op_suc) ? flags[flag_carry] : 1'b0;
                gp_reg_ie[tg_reg] = 1'b1;
                alu_flags_ie      = 1'b1;
            end
            op_cmp: begin
                alu_mode     = alu_sub;
                reg_l_ctl    = {1'b0, fo_reg};
                reg_r_ctl    = {1'b0, so_reg};
                alu_flags_ie = 1'b1;
            end
            op_cmi: begin
                alu_mode      = alu_sub;
                reg_l_ctl     = {1'b0, fo_reg};
                alu_r_mux_ctl = 1'b1;
                alu_flags_ie  = 1'b1;
            end
            op_jmp: begin
                alu_mode      = alu_pass_r;
                alu_r_mux_ctl = 1'b1;
                pc_ie         = jmp_en;
                pc_inc        = ~jmp_en;
            end
            op_jal: begin
                alu_mode          = alu_pass_r;
                alu_r_mux_ctl     = 1'b1;
                pc_ie             = 1'b1;
                pc_inc            = 1'b0;
                reg_sr_in         = 1'b1; // takes pc+1 via sr_value
                sr_pc_over        = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
            end
            op_srl: begin
                reg_sr_in         = 1'b1;
                gp_reg_ie[tg_reg] = 1'b1;
            end
            op_srs: begin
                reg_r_ctl = {1'b0, fo_reg};
                sr_ie     = 1'b1;
            end
            default: begin
                pc_inc = 1'b1; // nop
            end
        endcase
    end

    always_comb begin
        case (cond)
            cond_carry:   jmp_en = flags[flag_carry];
            cond_eq:      jmp_en = flags[flag_zero];
            cond_lt:      jmp_en = flags[flag_neg];
            cond_gt:      jmp_en = ~(flags[flag_neg] | flags[flag_zero]);
            cond_le:      jmp_en = flags[flag_neg] | flags[flag_zero];
            cond_ge:      jmp_en = ~flags[flag_neg];
            cond_ne:      jmp_en = ~flags[flag_zero];
            cond_ovf:     jmp_en = flags[flag_ovf];
            cond_ovf_alt: jmp_en = flags[flag_ovf];
            default:      jmp_en = 1'b1; // unconditional
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [3:0]        alu_mode,
    input  wire  [data_w-1:0] l_op,
    input  wire  [data_w-1:0] r_op,
    input  wire               alu_cin,
    input  wire               alu_flags_ie,
    output logic [data_w-1:0] result,
    output logic [4:0]        flags
);

    logic [data_w:0] sum;
    logic            ovf;
    logic [4:0]      flags_nxt;

    always_comb begin
        sum = '0;
        ovf = 1'b0;
        case (alu_mode)
            alu_add: begin
                sum = {1'b0, l_op} + {1'b0, r_op} + {{data_w{1'b0}}, alu_cin};
                ovf = (l_op[data_w-1] == r_op[data_w-1]) &&
                      (sum[data_w-1] != l_op[data_w-1]);
            end
            alu_sub: begin
                // msb of the wide result is the borrow
                sum = {1'b0, l_op} - {1'b0, r_op} - {{data_w{1'b0}}, alu_cin};
                ovf = (l_op[data_w-1] != r_op[data_w-1]) &&
                      (sum[data_w-1] != l_op[data_w-1]);
            end
            alu_pass_l: begin
                sum = {1'b0, l_op};
            end
            alu_pass_r: begin
                sum = {1'b0, r_op};
            end
            default: begin
                sum = '0;
            end
        endcase
    end

    assign result = sum[data_w-1:0];

    always_comb begin
        flags_nxt             = '0;
        flags_nxt[flag_zero]  = (result == '0);
        flags_nxt[flag_carry] = sum[data_w];
        flags_nxt[flag_neg]   = result[data_w-1] ^ ovf; // signed less-than
        flags_nxt[flag_ovf]   = ovf;
        flags_nxt[flag_par]   = ~^result; // even parity
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (alu_flags_ie) begin
            flags <= flags_nxt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [3:0]        reg_l_ctl,
    input  wire  [3:0]        reg_r_ctl,
    input  wire  [reg_cnt-1:0] gp_reg_ie,
    input  wire               reg_in_mux_ctl,
    input  wire               reg_sr_in,
    input  wire  [data_w-1:0] alu_result,
    input  wire  [data_w-1:0] ram_rdata,
    input  wire  [data_w-1:0] sr_value,
    output logic [data_w-1:0] l_data,
    output logic [data_w-1:0] r_data
);

    logic [data_w-1:0] regs [reg_cnt];
    logic [data_w-1:0] wb_data;

    always_comb begin
        if (reg_sr_in) begin
            wb_data = sr_value;
        end else if (reg_in_mux_ctl) begin
            wb_data = ram_rdata;
        end else begin
            wb_data = alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < reg_cnt; i++) begin
                if (gp_reg_ie[i]) begin
                    regs[i] <= wb_data;
                end
            end
        end
    end

    // index 8 and up reads as zero
    assign l_data = reg_l_ctl[3] ? '0 : regs[reg_l_ctl[2:0]];
    assign r_data = reg_r_ctl[3] ? '0 : regs[reg_r_ctl[2:0]];

endmodule

`default_nettype wire

// ==== rtl/program_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module program_counter import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               pc_inc,
    input  wire               pc_ie,
    input  wire               sr_ie,
    input  wire               sr_pc_over,
    input  wire  [data_w-1:0] jump_target,
    input  wire  [data_w-1:0] sr_data,
    output logic [data_w-1:0] pc,
    output logic [data_w-1:0] sr_value
);

    logic [data_w-1:0] sr;
    logic [data_w-1:0] pc_plus1;

    assign pc_plus1 = pc + data_w'(1);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_ie) begin
            pc <= jump_target;
        end else if (pc_inc) begin
            pc <= pc_plus1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sr <= '0;
        end else if (sr_ie) begin
            sr <= sr_data;
        end else if (sr_pc_over) begin
            sr <= pc_plus1; // return address on jal
        end
    end

    assign sr_value = sr_pc_over ? pc_plus1 : sr;

endmodule

`default_nettype wire

// ==== rtl/cpu_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [31:0]       imem_data,
    input  wire  [data_w-1:0] ram_rdata,
    input  wire               mem_busy,
    input  wire               mem_ready,
    output logic [data_w-1:0] imem_addr,
    output logic [data_w-1:0] ram_addr,
    output logic [data_w-1:0] ram_wdata,
    output logic              ram_read,
    output logic              ram_write
);

    logic               pc_inc;
    logic               pc_ie;
    logic               reg_in_mux_ctl;
    logic               alu_r_mux_ctl;
    logic               alu_cin;
    logic               dec_ram_write;
    logic               dec_ram_read;
    logic               alu_flags_ie;
    logic               reg_sr_in;
    logic               sr_ie;
    logic               sr_pc_over;
    logic [3:0]         alu_mode;
    logic [3:0]         reg_l_ctl;
    logic [3:0]         reg_r_ctl;
    logic [reg_cnt-1:0] gp_reg_ie;
    logic [4:0]         flags;
    logic [data_w-1:0]  imm;
    logic [data_w-1:0]  l_data;
    logic [data_w-1:0]  r_data;
    logic [data_w-1:0]  r_op;
    logic [data_w-1:0]  alu_result;
    logic [data_w-1:0]  sr_value;

    assign imm  = imem_data[31:16];
    assign r_op = alu_r_mux_ctl ? imm : r_data;

    assign ram_addr  = alu_result;
    assign ram_wdata = r_data;
    assign ram_read  = dec_ram_read & ~rst; // no requests during reset
    assign ram_write = dec_ram_write & ~rst;

    instr_decoder u_dec (
        .instr          (imem_data[15:0]),
        .flags          (flags),
        .mem_busy       (mem_busy),
        .mem_ready      (mem_ready),
        .pc_inc         (pc_inc),
        .pc_ie          (pc_ie),
        .reg_in_mux_ctl (reg_in_mux_ctl),
        .alu_r_mux_ctl  (alu_r_mux_ctl),
        .alu_cin        (alu_cin),
        .ram_write      (dec_ram_write),
        .ram_read       (dec_ram_read),
        .alu_flags_ie   (alu_flags_ie),
        .reg_sr_in      (reg_sr_in),
        .sr_ie          (sr_ie),
        .sr_pc_over     (sr_pc_over),
        .alu_mode       (alu_mode),
        .reg_l_ctl      (reg_l_ctl),
        .reg_r_ctl      (reg_r_ctl),
        .gp_reg_ie      (gp_reg_ie)
    );

    alu u_alu (
        .clk          (clk),
        .rst          (rst),
        .alu_mode     (alu_mode),
        .l_op         (l_data),
        .r_op         (r_op),
        .alu_cin      (alu_cin),
        .alu_flags_ie (alu_flags_ie),
        .result       (alu_result),
        .flags        (flags)
    );

    reg_file u_regs (
        .clk            (clk),
        .rst            (rst),
        .reg_l_ctl      (reg_l_ctl),
        .reg_r_ctl      (reg_r_ctl),
        .gp_reg_ie      (gp_reg_ie),
        .reg_in_mux_ctl (reg_in_mux_ctl),
        .reg_sr_in      (reg_sr_in),
        .alu_result     (alu_result),
        .ram_rdata      (ram_rdata),
        .sr_value       (sr_value),
        .l_data         (l_data),
        .r_data         (r_data)
    );

    program_counter u_pc (
        .clk         (clk),
        .rst         (rst),
        .pc_inc      (pc_inc),
        .pc_ie       (pc_ie),
        .sr_ie       (sr_ie),
        .sr_pc_over  (sr_pc_over),
        .jump_target (alu_result),
        .sr_data     (r_data),
        .pc          (imem_addr),
        .sr_value    (sr_value)
    );

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module mem_mdl import cpu_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire  [data_w-1:0] imem_addr,
    output logic [31:0]       imem_data,
    input  wire  [data_w-1:0] ram_addr,
    input  wire  [data_w-1:0] ram_wdata,
    input  wire               ram_read,
    input  wire               ram_write,
    output logic [data_w-1:0] ram_rdata,
    output logic              mem_busy,
    output logic              mem_ready
);

    logic [31:0]       rom [256];
    logic [data_w-1:0] ram [65536];
    logic              acc_rd;
    logic              acc_wr;
    logic              rd_pend;
    logic [data_w-1:0] rd_addr;
    int                busy_left;

    assign imem_data = rom[imem_addr[7:0]];

    initial begin
        for (int a = 0; a < 65536; a++) begin
            ram[a] = 16'(a * 40503) ^ 16'h3c5a; // odd multiplier, unique per address
        end
        mem_busy  = 1'b0;
        mem_ready = 1'b0;
        ram_rdata = '0;
        acc_rd    = 1'b0;
        acc_wr    = 1'b0;
        rd_pend   = 1'b0;
        rd_addr   = '0;
        busy_left = 0;
    end

    // requests are taken at the rising edge when not busy
    always @(posedge clk) begin
        acc_rd <= ram_read & ~mem_busy & ~rst;
        acc_wr <= ram_write & ~mem_busy & ~rst;
        if (ram_read && !mem_busy && !rst) begin
            rd_addr <= ram_addr;
        end
        if (ram_write && !mem_busy && !rst) begin
            ram[ram_addr] <= ram_wdata;
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            mem_busy  <= 1'b0;
            mem_ready <= 1'b0;
            rd_pend   <= 1'b0;
            busy_left <= 0;
        end else begin
            mem_ready <= 1'b0;
            if (acc_rd || acc_wr) begin
                mem_busy  <= 1'b1;
                busy_left <= $urandom % 4; // 1 to 4 busy cycles
                rd_pend   <= acc_rd;
            end else if (mem_busy) begin
                if (busy_left > 0) begin
                    busy_left <= busy_left - 1;
                end else begin
                    mem_busy <= 1'b0;
                    if (rd_pend) begin
                        mem_ready <= 1'b1;
                        ram_rdata <= ram[rd_addr];
                        rd_pend   <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/cpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    logic              clk;
    logic              rst;
    logic [31:0]       imem_data;
    logic [data_w-1:0] imem_addr;
    logic [data_w-1:0] ram_addr;
    logic [data_w-1:0] ram_wdata;
    logic [data_w-1:0] ram_rdata;
    logic              ram_read;
    logic              ram_write;
    logic              mem_busy;
    logic              mem_ready;

    logic [15:0] rm [reg_cnt];    // expected register values
    logic [15:0] ram_ref [1024];
    logic [15:0] exp_next [256];  // expected pc after each rom word
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    string       exp_name [$];
    logic        cf;
    logic [15:0] sr_m;
    logic [15:0] cmp_l;
    logic [15:0] cmp_r;
    logic [15:0] prev_pc;
    logic        prev_hold;
    logic        have_prev;
    logic        first_cycle;
    logic [6:0]  cur_op;
    int          pc_asm;
    int          mark_idx;
    int          halt_pc;
    int          cycles;
    int unsigned seed;
    int unsigned rnd;

    cpu_core dut (
        .clk       (clk),
        .rst       (rst),
        .imem_data (imem_data),
        .ram_rdata (ram_rdata),
        .mem_busy  (mem_busy),
        .mem_ready (mem_ready),
        .imem_addr (imem_addr),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_read  (ram_read),
        .ram_write (ram_write)
    );

    mem_mdl u_mem (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_read  (ram_read),
        .ram_write (ram_write),
        .ram_rdata (ram_rdata),
        .mem_busy  (mem_busy),
        .mem_ready (mem_ready)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_word(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [15:0] fill_value(input int a);
        logic [31:0] p;
        p = a * 40503;
        return p[15:0] ^ 16'h3c5a;
    endfunction

    task automatic emit(input logic [6:0] op, input logic [2:0] tg, input logic [2:0] fo,
                        input logic [2:0] so, input logic [15:0] imm);
        u_mem.rom[pc_asm] = {imm, so, fo, tg, op};
        exp_next[pc_asm]  = 16'(pc_asm + 1);
        pc_asm++;
    endtask

    task automatic expect_store(input string name, input logic [15:0] addr,
                                input logic [15:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        ram_ref[addr[9:0]] = data;
    endtask

    task automatic load_imm(input logic [2:0] tg, input logic [15:0] imm);
        emit(op_ldi, tg, 3'd0, 3'd0, imm);
        rm[tg] = imm;
    endtask

    task automatic store_reg(input string name, input logic [2:0] src, input logic [15:0] addr);
        emit(op_std, 3'd0, src, 3'd0, addr);
        expect_store(name, addr, rm[src]);
    endtask

    task automatic store_offset(input string name, input logic [2:0] src,
                                input logic [2:0] base, input logic [15:0] imm);
        emit(op_sto, 3'd0, src, base, imm);
        expect_store(name, rm[base] + imm, rm[src]);
    endtask

    task automatic load_direct(input logic [2:0] tg, input logic [15:0] addr);
        emit(op_ldd, tg, 3'd0, 3'd0, addr);
        rm[tg] = ram_ref[addr[9:0]];
    endtask

    task automatic load_offset(input logic [2:0] tg, input logic [2:0] fo, input logic [15:0] imm);
        logic [15:0] addr;
        addr = rm[fo] + imm;
        emit(op_ldo, tg, fo, 3'd0, imm);
        rm[tg] = ram_ref[addr[9:0]];
    endtask

    task automatic arith(input logic [6:0] op, input logic [2:0] tg, input logic [2:0] fo,
                         input logic [2:0] so, input logic [15:0] imm);
        int lhs;
        int rhs;
        int cin;
        int res;
        lhs = rm[fo];
        rhs = (op == op_adi) ? imm : rm[so];
        cin = (op == op_adc || op == op_suc) ? cf : 0;
        if (op == op_sub || op == op_suc) begin
            res = lhs - rhs - cin;
            cf  = (res < 0); // borrow
        end else begin
            res = lhs + rhs + cin;
            cf  = (res > 65535);
        end
        rm[tg] = res[15:0];
        emit(op, tg, fo, so, imm);
    endtask

    task automatic compare(input logic [2:0] fo, input logic [2:0] so, input logic use_imm,
                           input logic [15:0] imm);
        cmp_l = rm[fo];
        cmp_r = use_imm ? imm : rm[so];
        cf    = (cmp_l < cmp_r);
        emit(use_imm ? op_cmi : op_cmp, 3'd0, fo, so, imm);
    endtask

    function automatic logic cond_holds(input logic [3:0] c);
        int sl;
        int sr;
        int d;
        sl = $signed(cmp_l);
        sr = $signed(cmp_r);
        d  = sl - sr;
        case (c)
            cond_carry:             return cmp_l < cmp_r;
            cond_eq:                return sl == sr;
            cond_lt:                return sl < sr;
            cond_gt:                return sl > sr;
            cond_le:                return sl <= sr;
            cond_ge:                return sl >= sr;
            cond_ne:                return sl != sr;
            cond_ovf, cond_ovf_alt: return (d > 32767) || (d < -32768);
            default:                return 1'b1;
        endcase
    endfunction

    task automatic jump_on(input logic [3:0] c);
        logic        taken;
        int          at;
        logic [15:0] mark;
        taken = cond_holds(c);
        at    = pc_asm;
        mark  = 16'(16'h0180 + mark_idx);
        emit(op_jmp, c[2:0], {2'b00, c[3]}, 3'd0, 16'(at + 2));
        exp_next[at] = taken ? 16'(at + 2) : 16'(at + 1);
        emit(op_std, 3'd0, 3'd0, 3'd0, mark); // skipped when taken
        if (!taken) begin
            expect_store($sformatf("jmp_c%0d_fall", c), mark, rm[0]);
        end
        mark_idx++;
    endtask

    task automatic jump_link(input logic [2:0] tg);
        int at;
        at = pc_asm;
        emit(op_jal, tg, 3'd0, 3'd0, 16'(at + 2));
        exp_next[at] = 16'(at + 2);
        rm[tg] = 16'(at + 1);
        sr_m   = 16'(at + 1);
        emit(op_std, 3'd0, tg, 3'd0, 16'h01ff); // never reached
    endtask

    always @(posedge clk) begin
        cur_op = imem_data[6:0];
        if (rst) begin
            assert (!ram_read && !ram_write) else begin
                $display("memory request raised while reset is active");
                abort_run();
            end
            first_cycle = 1'b1;
            have_prev   = 1'b0;
        end else begin
            if (first_cycle) begin
                check_word("reset_pc", 16'h0000, imem_addr);
            end
            first_cycle = 1'b0;
            if (have_prev && imem_addr != prev_pc) begin
                check_word("next_pc", exp_next[prev_pc[7:0]], imem_addr);
            end
            if (have_prev && prev_hold) begin
                check_word("busy_hold_pc", prev_pc, imem_addr);
            end
            if (ram_write && !mem_busy) begin
                assert (exp_addr.size() > 0) else begin
                    $display("store to address %h when no store was expected", ram_addr);
                    abort_run();
                end
                check_word($sformatf("%s addr", exp_name[0]), exp_addr[0], ram_addr);
                check_word($sformatf("%s data", exp_name[0]), exp_data[0], ram_wdata);
                void'(exp_name.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
            prev_pc   = imem_addr;
            prev_hold = mem_busy && (cur_op == op_ldd || cur_op == op_ldo ||
                                     cur_op == op_std || cur_op == op_sto);
            have_prev = 1'b1;
        end
    end

    initial begin
        seed = 84566;
        rnd  = $urandom(seed);
        clk  = 1'b0;
        rst  = 1'b1;
        cf          = 1'b0;
        sr_m        = '0;
        prev_pc     = '0;
        prev_hold   = 1'b0;
        have_prev   = 1'b0;
        first_cycle = 1'b0;
        pc_asm      = 0;
        mark_idx    = 0;
        for (int r = 0; r < reg_cnt; r++) begin
            rm[r] = '0;
        end
        for (int a = 0; a < 1024; a++) begin
            ram_ref[a] = fill_value(a);
        end
        for (int a = 0; a < 256; a++) begin
            u_mem.rom[a] = 32'h0;
            exp_next[a]  = 16'(a + 1);
        end

        load_direct(3'd7, 16'h0210); // decoded while rst is still high
        store_reg("reset_ldd", 3'd7, 16'h0111);
        load_imm(3'd1, 16'h1234);
        store_reg("ldi_std", 3'd1, 16'h0100);
        load_imm(3'd2, 16'hfff0);
        load_imm(3'd3, 16'h0025);
        arith(op_add, 3'd4, 3'd2, 3'd3, 16'h0);
        arith(op_adc, 3'd5, 3'd2, 3'd3, 16'h0);
        store_reg("add", 3'd4, 16'h0101);
        store_reg("adc", 3'd5, 16'h0102); // lands while the last store is busy
        arith(op_adi, 3'd6, 3'd3, 3'd0, 16'h7fe0);
        arith(op_sub, 3'd7, 3'd3, 3'd2, 16'h0);
        arith(op_suc, 3'd6, 3'd6, 3'd3, 16'h0);
        store_reg("adi_suc", 3'd6, 16'h0103);
        store_reg("sub", 3'd7, 16'h0104);

        compare(3'd3, 3'd2, 1'b0, 16'h0);
        for (int c = 0; c < 10; c++) begin
            jump_on(4'(c));
        end
        compare(3'd3, 3'd0, 1'b1, 16'h0025);
        for (int c = 2; c < 8; c++) begin
            jump_on(4'(c));
        end
        load_imm(3'd1, 16'h8000);
        compare(3'd1, 3'd0, 1'b1, 16'h0001); // signed overflow
        jump_on(cond_ovf);
        jump_on(cond_ovf_alt);
        jump_on(cond_lt);
        jump_on(cond_ge);

        jump_link(3'd1);
        store_reg("jal_link", 3'd1, 16'h0120);
        emit(op_srl, 3'd2, 3'd0, 3'd0, 16'h0);
        rm[2] = sr_m;
        store_reg("srl", 3'd2, 16'h0121);
        load_imm(3'd3, 16'h5a5a);
        emit(op_srs, 3'd0, 3'd3, 3'd0, 16'h0);
        sr_m = rm[3];
        emit(op_srl, 3'd4, 3'd0, 3'd0, 16'h0);
        rm[4] = sr_m;
        store_reg("srs", 3'd4, 16'h0122);

        load_direct(3'd5, 16'h0102);
        load_imm(3'd1, 16'h0100);
        load_offset(3'd6, 3'd1, 16'h0003);
        load_direct(3'd7, 16'h0200); // untouched, still the fill pattern
        store_reg("ldd_stored", 3'd5, 16'h0130);
        store_reg("ldo", 3'd6, 16'h0131);
        store_reg("ldd_fill", 3'd7, 16'h0132);
        store_offset("sto", 3'd7, 3'd1, 16'h0040);
        load_offset(3'd2, 3'd1, 16'h0040);
        emit(op_mov, 3'd3, 3'd2, 3'd0, 16'h0);
        rm[3] = rm[2];
        store_reg("ldo_sto_mov", 3'd3, 16'h0133);

        halt_pc = pc_asm;
        emit(op_jmp, 3'd0, 3'd0, 3'd0, 16'(halt_pc));
        exp_next[halt_pc] = 16'(halt_pc);

        repeat (4) @(negedge clk);
        rst = 1'b0;

        cycles = 0;
        while (!(imem_addr == 16'(halt_pc) && exp_addr.size() == 0) && cycles < 2000) begin
            @(negedge clk);
            cycles++;
        end
        if (imem_addr == 16'(halt_pc) && exp_addr.size() == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("timeout: program did not reach its halt loop with all stores seen");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/program_counter.sv
rtl/cpu_core.sv
tests/mem_model.sv
tests/cpu_tb.sv
